// ==== conv_load_controller.f ====
hdl/conv_load_pkg.sv
hdl/load_walker.sv
hdl/tile_sequencer.sv
hdl/conv_load_controller.sv
tests/tb_clock_gen.sv
tests/tb_conv_load_controller.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_conv_load_controller
FILELIST = conv_load_controller.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
PASS_MSG = test passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_conv_load_controller.sv ====
`timescale 1ns/1ns

module tb_conv_load_controller;

    localparam int px_log2        = 5;
    localparam int buffers_num    = 3;
    localparam int ddr_load_ratio = 2;
    localparam int ifs_log2       = 1;

    localparam int cfg_s     = 1;
    localparam int cfg_ix    = 64;
    localparam int cfg_iy    = 8;
    localparam int cfg_nif   = 4;
    localparam int cfg_spare = 32;

    // feature steps times words per row times rows
    localparam int expected_reads =
        (cfg_nif / ddr_load_ratio) * (cfg_ix / (1 << px_log2)) * cfg_iy;
    // tile columns times tile rows, the last tile row may be short
    localparam int expected_tiles =
        (cfg_ix / cfg_spare) * ((cfg_iy + 3 * cfg_s - 1) / (3 * cfg_s));
    localparam int beat_timeout  = 100;
    localparam int reset_timeout = 20;

    logic                     clk;
    logic                     reset;
    conv_load_pkg::conv_cfg_t cfg_init;
    logic                     start;
    logic                     continue_load;
    logic                     data_valid;
    conv_load_pkg::load_pos_t ddr_rd;
    logic                     ddr_rd_valid;
    conv_load_pkg::buf_wr_t   buf_wr;
    logic                     buf_wr_valid;
    logic                     tile_fin;
    logic                     tile0_fin;
    logic                     tilen_fin;

    conv_load_pkg::load_pos_t rd_q[$];
    conv_load_pkg::load_pos_t q_front;
    int                       q_count;
    int                       reads_in_pass;
    int                       tile0_in_pass;
    int                       tiles_in_pass;
    logic                     started;
    logic                     first_read;
    logic                     hold_reads;
    logic                     pass_done;
    conv_load_pkg::idx_t      prev_if;
    conv_load_pkg::idx_t      next_if;
    int                       exp_rd_addr;
    int                       exp_buf_idx;
    int                       exp_buf_row;
    int                       exp_buf_addr;
    int                       seed;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    conv_load_controller #(
        .pixels_in_row_log2 (px_log2),
        .buffers_num        (buffers_num),
        .ddr_load_ratio     (ddr_load_ratio),
        .ifs_in_row_log2    (ifs_log2)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .cfg_init      (cfg_init),
        .start         (start),
        .continue_load (continue_load),
        .data_valid    (data_valid),
        .ddr_rd        (ddr_rd),
        .ddr_rd_valid  (ddr_rd_valid),
        .buf_wr        (buf_wr),
        .buf_wr_valid  (buf_wr_valid),
        .tile_fin      (tile_fin),
        .tile0_fin     (tile0_fin),
        .tilen_fin     (tilen_fin)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
    endtask

    // word of a pixel group, rows outermost and feature pairs innermost
    function automatic int word_index(input int row, input int col, input int feat);
        int words_per_row;
        int feat_groups;
        words_per_row = cfg_ix / (1 << px_log2);
        feat_groups   = cfg_nif / (1 << ifs_log2);
        return (row * words_per_row + col / (1 << px_log2)) * feat_groups
               + (feat - 1) / (1 << ifs_log2);
    endfunction

    ////////////////////
    // reference state

    // reads in flight, oldest first
    always @(posedge clk) begin
        if (reset) begin
            rd_q.delete();
            q_count <= 0;
            q_front <= '0;
        end else begin
            if (buf_wr_valid && rd_q.size() > 0) begin
                void'(rd_q.pop_front());
            end
            if (ddr_rd_valid) begin
                rd_q.push_back(ddr_rd);
            end
            q_count <= rd_q.size();
            q_front <= (rd_q.size() > 0) ? rd_q[0] : '0;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            started       <= 1'b0;
            first_read    <= 1'b0;
            hold_reads    <= 1'b0;
            reads_in_pass <= 0;
            tile0_in_pass <= 0;
            tiles_in_pass <= 0;
            prev_if       <= conv_load_pkg::idx_t'(1);
        end else begin
            if (start) begin
                started       <= 1'b1;
                first_read    <= 1'b1;
                reads_in_pass <= 0;
                tile0_in_pass <= 0;
                tiles_in_pass <= 0;
            end else begin
                if (ddr_rd_valid) begin
                    first_read    <= 1'b0;
                    reads_in_pass <= reads_in_pass + 1;
                end
                if (tile0_fin) begin
                    tile0_in_pass <= tile0_in_pass + 1;
                end
                if (tile_fin) begin
                    tiles_in_pass <= tiles_in_pass + 1;
                end
            end
            if (ddr_rd_valid) begin
                prev_if <= ddr_rd.if_start;
            end
            // host view of the stall
            if (tilen_fin) begin
                hold_reads <= 1'b1;
            end else if (continue_load) begin
                hold_reads <= 1'b0;
            end
        end
    end

    always_comb begin
        if (int'(prev_if) + ddr_load_ratio - 1 >= cfg_nif) begin
            next_if = conv_load_pkg::idx_t'(1);
        end else begin
            next_if = prev_if + conv_load_pkg::idx_t'(ddr_load_ratio);
        end
    end

    // stride 1 puts row r in buffer r mod 3, at tile row r / 3
    always_comb begin
        exp_rd_addr  = word_index(int'(ddr_rd.row), int'(ddr_rd.col_start),
                                  int'(ddr_rd.if_start));
        exp_buf_idx  = int'(q_front.row) % buffers_num + 1;
        exp_buf_row  = int'(q_front.row) / buffers_num;
        exp_buf_addr = word_index(exp_buf_row, int'(q_front.col_start),
                                  int'(q_front.if_start));
    end

    ////////////////////
    // checks

    a_idle_before_start: assert property (@(posedge clk) disable iff (reset)
        !started |-> !ddr_rd_valid && !tile_fin && !tile0_fin && !tilen_fin)
        else report_mismatch("read or tile pulse before start");

    a_first_read: assert property (@(posedge clk) disable iff (reset)
        ddr_rd_valid && first_read |-> ddr_rd.row == '0 && ddr_rd.col_start == '0
            && ddr_rd.if_start == conv_load_pkg::idx_t'(1))
        else report_mismatch("first read of a pass is not at row 0, col 0, feature 1");

    a_if_step: assert property (@(posedge clk) disable iff (reset)
        ddr_rd_valid && !first_read |-> ddr_rd.if_start == next_if)
        else report_mismatch("feature start index did not step as expected");

    a_read_in_map: assert property (@(posedge clk) disable iff (reset)
        ddr_rd_valid |-> ddr_rd.row < cfg_init.iy && ddr_rd.col_start < cfg_init.ix)
        else report_mismatch("read position outside the feature map");

    a_read_addr: assert property (@(posedge clk) disable iff (reset)
        ddr_rd_valid |-> int'(ddr_rd.addr) == exp_rd_addr)
        else report_mismatch("read address does not match its row, column and feature");

    a_beat_matches_read: assert property (@(posedge clk) disable iff (reset)
        buf_wr_valid |-> q_count > 0 && buf_wr.pos.row == q_front.row
            && buf_wr.pos.col_start == q_front.col_start
            && buf_wr.pos.if_start == q_front.if_start)
        else report_mismatch("buffer beat does not match the oldest read");

    a_beat_slot: assert property (@(posedge clk) disable iff (reset)
        buf_wr_valid |-> int'(buf_wr.buf_idx) == exp_buf_idx
            && int'(buf_wr.buf_row) == exp_buf_row
            && int'(buf_wr.pos.addr) == exp_buf_addr)
        else report_mismatch("buffer index, buffer row or write address is wrong");

    a_beat_follows_valid: assert property (@(posedge clk) disable iff (reset)
        buf_wr_valid == data_valid)
        else report_mismatch("buf_wr_valid differs from data_valid");

    a_tile_pulses: assert property (@(posedge clk) disable iff (reset)
        (tile0_fin || tilen_fin) |-> tile_fin && !(tile0_fin && tile0_in_pass != 0))
        else report_mismatch("tile pulse without tile_fin or a second tile0_fin");

    a_stall_holds_reads: assert property (@(posedge clk) disable iff (reset)
        hold_reads |-> !ddr_rd_valid)
        else report_mismatch("read issued while waiting for continue_load");

    a_read_budget: assert property (@(posedge clk) disable iff (reset)
        ddr_rd_valid |-> reads_in_pass < expected_reads)
        else report_mismatch("read issued after the last read of the pass");

    a_pass_totals: assert property (@(posedge clk) disable iff (reset)
        pass_done |-> reads_in_pass == expected_reads && tile0_in_pass == 1
            && tiles_in_pass == expected_tiles)
        else report_mismatch("wrong read, tile or tile0_fin count for the pass");

    ////////////////////
    // stimulus

    // host answers each later tile after a few cycles
    initial begin
        int delay;
        continue_load = 1'b0;
        forever begin
            @(posedge clk);
            if (tilen_fin) begin
                delay = 3 + ($random(seed) & 3);
                repeat (delay) @(negedge clk);
                continue_load = 1'b1;
                @(negedge clk);
                continue_load = 1'b0;
            end
        end
    end

    task automatic run_pass();
        int beats;
        int idle;
        beats = 0;
        idle  = 0;
        start = 1'b1;
        @(negedge clk);
        start     = 1'b0;
        pass_done = 1'b0;
        while (beats < expected_reads && idle < beat_timeout) begin
            data_valid = (q_count > 0) && (($random(seed) & 3) != 0);
            @(negedge clk);
            if (data_valid) begin
                beats = beats + 1;
                idle  = 0;
            end else begin
                idle = idle + 1;
            end
        end
        data_valid = 1'b0;
        if (beats < expected_reads) begin
            abort_run("timeout: returned data beats stopped before the pass ended");
        end else begin
            pass_done = 1'b1;
        end
    endtask

    initial begin
        int cycles;
        seed       = 15021;
        start      = 1'b0;
        data_valid = 1'b0;
        pass_done  = 1'b0;
        cfg_init                = '0;
        cfg_init.s              = conv_load_pkg::log_t'(cfg_s);
        cfg_init.ix             = conv_load_pkg::idx_t'(cfg_ix);
        cfg_init.iy             = conv_load_pkg::idx_t'(cfg_iy);
        cfg_init.nif            = conv_load_pkg::idx_t'(cfg_nif);
        cfg_init.nif_log2       = conv_load_pkg::log_t'($clog2(cfg_nif));
        cfg_init.ix_log2        = conv_load_pkg::log_t'($clog2(cfg_ix));
        cfg_init.words_per_load = conv_load_pkg::idx_t'(cfg_spare / (1 << px_log2));
        cfg_init.spare_words    = conv_load_pkg::idx_t'(cfg_spare);

        cycles = 0;
        while (reset && cycles < reset_timeout) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (reset) begin
            abort_run("timeout: reset was never released");
        end else begin
            // quiet period before the first start
            repeat (10) @(negedge clk);
            run_pass();
            // second pass starts while the last tile still holds the reads
            run_pass();
            @(negedge clk);
            pass_done = 1'b0;
            repeat (20) @(negedge clk);
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // two rising edges with reset high, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== hdl/conv_load_controller.sv ====
`timescale 1ns/1ns

module conv_load_controller #(
    parameter int pixels_in_row_log2 = 5,
    parameter int buffers_num        = 3,
    parameter int ddr_load_ratio     = 2,
    parameter int ifs_in_row_log2    = 1
) (
    input  logic                     clk,
    input  logic                     reset,
    input  conv_load_pkg::conv_cfg_t cfg_init,
    input  logic                     start,
    input  logic                     continue_load,
    input  logic                     data_valid,
    output conv_load_pkg::load_pos_t ddr_rd,
    output logic                     ddr_rd_valid,
    output conv_load_pkg::buf_wr_t   buf_wr,
    output logic                     buf_wr_valid,
    output logic                     tile_fin,
    output logic                     tile0_fin,
    output logic                     tilen_fin
);

    conv_load_pkg::conv_cfg_t cfg;

    logic ddr_step;
    logic ddr_pass_end;

    conv_load_pkg::load_pos_t             buf_pos;
    logic [conv_load_pkg::buf_idx_w-1:0]  buf_idx;
    conv_load_pkg::idx_t                  buf_row;
    logic                                 buf_tile_row_end;
    logic                                 buf_first_col;
    logic                                 buf_first_row;

    // configuration follows the inputs while reset is held
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= cfg_init;
        end
    end

    ////////////////////
    // read side walk

    load_walker #(
        .pixels_in_row_log2 (pixels_in_row_log2),
        .buffers_num        (buffers_num),
        .ddr_load_ratio     (ddr_load_ratio),
        .ifs_in_row_log2    (ifs_in_row_log2)
    ) u_ddr_walker (
        .clk            (clk),
        .reset          (reset),
        .cfg            (cfg),
        .step           (ddr_step),
        .pos            (ddr_rd),
        .buf_idx        (),
        .buf_row        (),
        .tile_row_end   (),
        .first_tile_col (),
        .first_tile_row (),
        .pass_end       (ddr_pass_end)
    );

    assign ddr_rd_valid = ddr_step;

    ////////////////////
    // buffer side walk

    // one step per returned beat
    load_walker #(
        .pixels_in_row_log2 (pixels_in_row_log2),
        .buffers_num        (buffers_num),
        .ddr_load_ratio     (ddr_load_ratio),
        .ifs_in_row_log2    (ifs_in_row_log2)
    ) u_buf_walker (
        .clk            (clk),
        .reset          (reset),
        .cfg            (cfg),
        .step           (data_valid),
        .pos            (buf_pos),
        .buf_idx        (buf_idx),
        .buf_row        (buf_row),
        .tile_row_end   (buf_tile_row_end),
        .first_tile_col (buf_first_col),
        .first_tile_row (buf_first_row),
        .pass_end       ()
    );

    // buffer address uses the row slot instead of the feature map row
    always_comb begin
        buf_wr.buf_idx       = buf_idx;
        buf_wr.buf_row       = buf_row;
        buf_wr.pos.row       = buf_pos.row;
        buf_wr.pos.col_start = buf_pos.col_start;
        buf_wr.pos.if_start  = buf_pos.if_start;
        buf_wr.pos.addr      = conv_load_pkg::word_addr(buf_row, buf_pos.col_start,
                                                        buf_pos.if_start, cfg.nif_log2,
                                                        cfg.ix_log2, pixels_in_row_log2,
                                                        ifs_in_row_log2);
    end

    assign buf_wr_valid = data_valid;

    tile_sequencer u_tile_sequencer (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .continue_load  (continue_load),
        .ddr_pass_end   (ddr_pass_end),
        .tile_row_end   (buf_tile_row_end),
        .first_tile_col (buf_first_col),
        .first_tile_row (buf_first_row),
        .ddr_step       (ddr_step),
        .tile_fin       (tile_fin),
        .tile0_fin      (tile0_fin),
        .tilen_fin      (tilen_fin)
    );

endmodule

// ==== hdl/tile_sequencer.sv ====
`timescale 1ns/1ns

module tile_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic continue_load,
    input  logic ddr_pass_end,
    input  logic tile_row_end,
    input  logic first_tile_col,
    input  logic first_tile_row,
    output logic ddr_step,
    output logic tile_fin,
    output logic tile0_fin,
    output logic tilen_fin
);

    logic running;
    logic stalled;

    // read walk runs from start to the end of the pass
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
        end else if (ddr_pass_end) begin
            running <= 1'b0;
        end
    end

    // hold the reads after a later tile until the host resumes
    always_ff @(posedge clk) begin
        if (reset) begin
            stalled <= 1'b0;
        end else if (tilen_fin) begin
            stalled <= 1'b1;
        end else if (continue_load) begin
            stalled <= 1'b0;
        end
    end

    assign ddr_step = running && !stalled;

    ////////////////////
    // tile pulses

    assign tile_fin  = tile_row_end;
    assign tile0_fin = tile_row_end && first_tile_col && first_tile_row;
    assign tilen_fin = tile_row_end && !first_tile_col && !first_tile_row;

    a_tile_pulses_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(tile0_fin && tilen_fin)
    );

endmodule

// ==== hdl/load_walker.sv ====
`timescale 1ns/1ns

module load_walker #(
    parameter int pixels_in_row_log2 = 5,
    parameter int buffers_num        = 3,
    parameter int ddr_load_ratio     = 2,
    parameter int ifs_in_row_log2    = 1
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  conv_load_pkg::conv_cfg_t                cfg,
    input  logic                                    step,
    output conv_load_pkg::load_pos_t                pos,
    output logic [conv_load_pkg::buf_idx_w-1:0]     buf_idx,
    output conv_load_pkg::idx_t                     buf_row,
    output logic                                    tile_row_end,
    output logic                                    first_tile_col,
    output logic                                    first_tile_row,
    output logic                                    pass_end
);

    localparam conv_load_pkg::idx_t px_per_word = conv_load_pkg::idx_t'(1 << pixels_in_row_log2);
    localparam conv_load_pkg::idx_t ratio_step  = conv_load_pkg::idx_t'(ddr_load_ratio);
    localparam conv_load_pkg::idx_t bufy_limit  = conv_load_pkg::idx_t'(buffers_num);
    localparam conv_load_pkg::idx_t one         = conv_load_pkg::idx_t'(1);

    // loop counters, innermost first
    conv_load_pkg::idx_t if_cnt;
    conv_load_pkg::idx_t word_cnt;
    conv_load_pkg::idx_t bufy_cnt;
    conv_load_pkg::idx_t siy_cnt;
    conv_load_pkg::idx_t tix_cnt;
    conv_load_pkg::idx_t tiy_cnt;
    conv_load_pkg::idx_t row_cnt3;

    logic if_end;
    logic word_end;
    logic bufy_end;
    logic siy_end;
    logic tix_end;
    logic tiy_end;

    conv_load_pkg::idx_t s_w;
    conv_load_pkg::idx_t tiy_step;
    conv_load_pkg::idx_t row;
    conv_load_pkg::idx_t col_start;
    conv_load_pkg::idx_t col_end;
    conv_load_pkg::idx_t if_end_idx;
    logic                last_row;

    assign s_w      = conv_load_pkg::idx_t'(cfg.s);
    assign tiy_step = s_w + (s_w << 1);

    ////////////////////
    // index arithmetic

    // zero based row and column, one based feature
    assign row       = tiy_cnt - one + (siy_cnt << 1) + siy_cnt - 16'd3 + bufy_cnt - one;
    assign col_start = tix_cnt - one + (word_cnt << pixels_in_row_log2) - px_per_word;

    // clamped ends of the current word
    assign col_end = (col_start + px_per_word - one >= cfg.ix) ? cfg.ix - one
                                                               : col_start + px_per_word - one;
    assign if_end_idx = (if_cnt + ratio_step - one > cfg.nif) ? cfg.nif
                                                              : if_cnt + ratio_step - one;

    assign last_row = (row == cfg.iy - one);

    ////////////////////
    // level ends

    assign if_end   = step && (if_end_idx == cfg.nif);
    assign word_end = if_end && ((word_cnt == cfg.words_per_load) || (col_end == cfg.ix - one));
    assign bufy_end = word_end && ((bufy_cnt == bufy_limit) || last_row);
    assign siy_end  = bufy_end && ((siy_cnt == s_w) || last_row);
    assign tix_end  = siy_end && (tix_cnt + cfg.spare_words - one >= cfg.ix);
    assign tiy_end  = tix_end && ((tiy_cnt + tiy_step - one >= cfg.iy) || last_row);

    always_ff @(posedge clk) begin
        if (reset) begin
            if_cnt   <= one;
            word_cnt <= one;
            bufy_cnt <= one;
            siy_cnt  <= one;
            tix_cnt  <= one;
            tiy_cnt  <= one;
            row_cnt3 <= '0;
        end else begin
            if (step) begin
                if_cnt <= if_end ? one : if_cnt + ratio_step;
            end
            if (if_end) begin
                word_cnt <= word_end ? one : word_cnt + one;
            end
            if (word_end) begin
                bufy_cnt <= bufy_end ? one : bufy_cnt + one;
            end
            if (bufy_end) begin
                siy_cnt <= siy_end ? one : siy_cnt + one;
            end
            if (siy_end) begin
                tix_cnt <= tix_end ? one : tix_cnt + cfg.spare_words;
            end
            // tile row step also advances the row slot in the buffers
            if (tix_end) begin
                tiy_cnt  <= tiy_end ? one : tiy_cnt + tiy_step;
                row_cnt3 <= tiy_end ? '0 : row_cnt3 + one;
            end
        end
    end

    ////////////////////
    // outputs

    assign pos.row       = row;
    assign pos.col_start = col_start;
    assign pos.if_start  = if_cnt;
    assign pos.addr      = conv_load_pkg::word_addr(row, col_start, if_cnt, cfg.nif_log2,
                                                    cfg.ix_log2, pixels_in_row_log2,
                                                    ifs_in_row_log2);

    assign buf_idx = bufy_cnt[conv_load_pkg::buf_idx_w-1:0];

    // row within the three buffers, strides 1 and 2 only
    assign buf_row = (cfg.s == 4'd1) ? row_cnt3 + siy_cnt - one :
                     (cfg.s == 4'd2) ? (row_cnt3 << 1) + siy_cnt - one :
                     '0;

    assign tile_row_end   = siy_end;
    assign first_tile_col = (tix_cnt == one);
    assign first_tile_row = (tiy_cnt == one);
    assign pass_end       = tiy_end;

    ////////////////////
    // checks

    a_counter_limits: assert property (
        @(posedge clk) disable iff (reset)
        (bufy_cnt <= bufy_limit) && (siy_cnt <= s_w) && (word_cnt <= cfg.words_per_load)
        && (if_cnt <= cfg.nif) && (tix_cnt <= cfg.ix) && (tiy_cnt <= cfg.iy)
    );

endmodule

// ==== hdl/conv_load_pkg.sv ====
package conv_load_pkg;

    ////////////////////
    // sizing

    parameter int idx_w = 16;
    parameter int log_w = 4;
    parameter int buf_idx_w = 2;

    typedef logic [idx_w-1:0] idx_t;
    typedef logic [log_w-1:0] log_t;

    ////////////////////
    // configuration and positions

    // spare_words is the pixel span of one load step
    typedef struct packed {
        log_t s;
        idx_t ix;
        idx_t iy;
        idx_t nif;
        log_t nif_log2;
        log_t ix_log2;
        idx_t words_per_load;
        idx_t spare_words;
    } conv_cfg_t;

    typedef struct packed {
        idx_t row;
        idx_t col_start;
        idx_t if_start;
        idx_t addr;
    } load_pos_t;

    typedef struct packed {
        logic [buf_idx_w-1:0] buf_idx;
        idx_t                 buf_row;
        load_pos_t            pos;
    } buf_wr_t;

    // word address of a pixel group, row major with features innermost
    function automatic idx_t word_addr(
        input idx_t row,
        input idx_t col,
        input idx_t if_start,
        input log_t nif_log2,
        input log_t ix_log2,
        input int   px_log2,
        input int   ifs_log2
    );
        int               feat_sh;
        int               row_sh;
        logic [2*idx_w-1:0] col_wide;
        idx_t             row_part;
        idx_t             col_part;
        idx_t             if_part;
        feat_sh  = int'(nif_log2) - ifs_log2;
        row_sh   = feat_sh + int'(ix_log2) - px_log2;
        row_part = row << row_sh;
        col_wide = {{idx_w{1'b0}}, col} << feat_sh;
        col_part = idx_t'(col_wide >> px_log2);
        if_part  = idx_t'((if_start - idx_t'(1)) >> ifs_log2);
        return row_part + col_part + if_part;
    endfunction

endpackage
